//--- design/ooo_pkg.sv
package ooo_pkg;

    // datapath widths
    localparam int data_w  = 32;
    localparam int addr_w  = 32;
    localparam int regnm_w = 5;
    localparam int nick_w  = 5;

    // architectural registers, x0 included
    localparam int reg_count = 2 ** regnm_w;

    // usable rob slots, tags 1..31
    localparam int rob_entries = 31;

    typedef logic [data_w-1:0]  data_t;
    typedef logic [addr_w-1:0]  addr_t;
    typedef logic [regnm_w-1:0] regnm_t;
    typedef logic [nick_w-1:0]  nick_t;

    // tag 0 is never handed out
    localparam nick_t nick_none  = nick_t'(0);
    localparam nick_t nick_first = nick_t'(1);
    localparam nick_t nick_last  = nick_t'(rob_entries);

    localparam regnm_t reg_zero = regnm_t'(0);

    // pc step for a not-taken branch
    localparam addr_t pc_step = addr_t'(4);

    // retirement class of an entry
    //   op_alu / op_load  write rd at commit
    //   op_store          goes to the store buffer
    //   op_branch         checked against its prediction
    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_load   = 2'd1,
        op_store  = 2'd2,
        op_branch = 2'd3
    } op_e;

endpackage

//--- design/rob.sv
module rob (
    input  logic            clk,
    input  logic            arst_n,

    // allocate
    input  logic            alloc_en,
    input  ooo_pkg::op_e    alloc_op,
    input  ooo_pkg::regnm_t alloc_rd,
    input  logic            alloc_pred_taken,
    input  ooo_pkg::addr_t  alloc_pc,
    output logic            full,
    output ooo_pkg::nick_t  alloc_nick,
    output logic            alloc_accept,

    // execute result
    input  logic            ex_en,
    input  ooo_pkg::nick_t  ex_nick,
    input  ooo_pkg::data_t  ex_data,
    input  logic            ex_taken,
    input  ooo_pkg::addr_t  ex_target,

    // store buffer handshake
    input  logic            store_done_en,
    input  ooo_pkg::nick_t  store_done_nick,
    output logic            store_commit_en,
    output ooo_pkg::nick_t  store_commit_nick,

    // commit
    output logic            commit_en,
    output ooo_pkg::regnm_t commit_rd,
    output ooo_pkg::data_t  commit_data,
    output ooo_pkg::nick_t  commit_nick,

    // redirect
    output logic            flush,
    output ooo_pkg::addr_t  flush_pc
);

    // per-entry control
    logic [ooo_pkg::rob_entries:1] occupied;
    logic [ooo_pkg::rob_entries:1] done;

    // per-entry payload
    ooo_pkg::op_e    op_q     [1:ooo_pkg::rob_entries];
    ooo_pkg::regnm_t rd_q     [1:ooo_pkg::rob_entries];
    ooo_pkg::data_t  data_q   [1:ooo_pkg::rob_entries];
    logic            pred_q   [1:ooo_pkg::rob_entries];
    logic            taken_q  [1:ooo_pkg::rob_entries];
    ooo_pkg::addr_t  target_q [1:ooo_pkg::rob_entries];
    ooo_pkg::addr_t  pc_q     [1:ooo_pkg::rob_entries];

    ooo_pkg::nick_t head;
    ooo_pkg::nick_t tail;

    logic ex_write;
    logic store_retire;
    logic retire;
    logic mispredict;

    function automatic ooo_pkg::nick_t next_nick(input ooo_pkg::nick_t n);
        ooo_pkg::nick_t nxt;
        // skip tag 0 on wrap
        if (n == ooo_pkg::nick_last) begin
            nxt = ooo_pkg::nick_first;
        end else begin
            nxt = n + ooo_pkg::nick_first;
        end
        return nxt;
    endfunction

    assign full         = &occupied;
    assign alloc_nick   = tail;
    // nothing enters while the redirect is in flight
    assign alloc_accept = alloc_en && !full && !flush;

    // head decode
    assign commit_en         = occupied[head] && done[head] && (op_q[head] != ooo_pkg::op_store);
    assign commit_rd         = rd_q[head];
    assign commit_data       = data_q[head];
    assign commit_nick       = head;
    assign store_commit_en   = occupied[head] && (op_q[head] == ooo_pkg::op_store);
    assign store_commit_nick = head;

    assign store_retire = store_commit_en && store_done_en && (store_done_nick == head);
    assign retire       = commit_en || store_retire;
    assign mispredict   = commit_en && (op_q[head] == ooo_pkg::op_branch)
                          && (taken_q[head] != pred_q[head]);

    // late results for a flushed or retired slot are dropped
    assign ex_write = ex_en && !flush && (ex_nick != ooo_pkg::nick_none)
                      && occupied[ex_nick] && !done[ex_nick];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occupied <= '0;
            done     <= '0;
            head     <= ooo_pkg::nick_first;
            tail     <= ooo_pkg::nick_first;
            flush    <= 1'b0;
        end else begin
            flush <= mispredict;
            if (mispredict) begin
                // branch retires, everything younger is gone
                occupied <= '0;
                done     <= '0;
                head     <= ooo_pkg::nick_first;
                tail     <= ooo_pkg::nick_first;
            end else begin
                if (alloc_accept) begin
                    occupied[tail] <= 1'b1;
                    done[tail]     <= 1'b0;
                    tail           <= next_nick(tail);
                end
                if (ex_write) begin
                    done[ex_nick] <= 1'b1;
                end
                if (retire) begin
                    occupied[head] <= 1'b0;
                    done[head]     <= 1'b0;
                    head           <= next_nick(head);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_accept) begin
            op_q[tail]   <= alloc_op;
            rd_q[tail]   <= alloc_rd;
            pred_q[tail] <= alloc_pred_taken;
            pc_q[tail]   <= alloc_pc;
        end
        if (ex_write) begin
            data_q[ex_nick]   <= ex_data;
            taken_q[ex_nick]  <= ex_taken;
            target_q[ex_nick] <= ex_target;
        end
        // redirect to the resolved path
        if (mispredict) begin
            flush_pc <= taken_q[head] ? target_q[head] : pc_q[head] + ooo_pkg::pc_step;
        end
    end

endmodule

//--- design/rename_table.sv
module rename_table (
    input  logic            clk,
    input  logic            arst_n,

    // new youngest writer
    input  logic            alloc_accept,
    input  ooo_pkg::regnm_t alloc_rd,
    input  ooo_pkg::nick_t  alloc_nick,

    // retiring writer
    input  logic            commit_en,
    input  ooo_pkg::regnm_t commit_rd,
    input  ooo_pkg::nick_t  commit_nick,

    input  logic            flush,

    // operand lookup
    input  ooo_pkg::regnm_t rs_regnm,
    output logic            rs_busy,
    output ooo_pkg::nick_t  rs_nick
);

    logic [ooo_pkg::reg_count-1:0] busy;
    ooo_pkg::nick_t                nick_map [ooo_pkg::reg_count];

    // x0 is never renamed
    assign rs_busy = busy[rs_regnm];
    assign rs_nick = nick_map[rs_regnm];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
            for (int r = 0; r < ooo_pkg::reg_count; r++) begin
                nick_map[r] <= ooo_pkg::nick_none;
            end
        end else if (flush) begin
            busy <= '0;
            for (int r = 0; r < ooo_pkg::reg_count; r++) begin
                nick_map[r] <= ooo_pkg::nick_none;
            end
        end else begin
            for (int r = 1; r < ooo_pkg::reg_count; r++) begin
                if (alloc_accept && (alloc_rd == ooo_pkg::regnm_t'(r))) begin
                    // a newer writer beats the retiring one
                    busy[r]     <= 1'b1;
                    nick_map[r] <= alloc_nick;
                end else if (commit_en && (commit_rd == ooo_pkg::regnm_t'(r))
                             && (nick_map[r] == commit_nick)) begin
                    // only the youngest writer frees the register
                    busy[r]     <= 1'b0;
                    nick_map[r] <= ooo_pkg::nick_none;
                end
            end
        end
    end

endmodule

//--- design/reg_file.sv
module reg_file (
    input  logic            clk,
    input  logic            arst_n,

    // commit write port
    input  logic            commit_en,
    input  ooo_pkg::regnm_t commit_rd,
    input  ooo_pkg::data_t  commit_data,

    // operand read port
    input  ooo_pkg::regnm_t rs_regnm,
    output ooo_pkg::data_t  rs_data
);

    // x1..x31 only, x0 has no storage
    ooo_pkg::data_t regs [1:ooo_pkg::reg_count-1];

    logic wr_en;

    assign wr_en = commit_en && (commit_rd != ooo_pkg::reg_zero);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 1; r < ooo_pkg::reg_count; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            regs[commit_rd] <= commit_data;
        end
    end

    // async read, x0 reads zero
    always_comb begin
        if (rs_regnm == ooo_pkg::reg_zero) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_regnm];
        end
    end

endmodule

//--- design/ooo_backend_top.sv
module ooo_backend_top (
    input  logic            clk,
    input  logic            arst_n,

    // front end
    input  logic            alloc_en,
    input  ooo_pkg::op_e    alloc_op,
    input  ooo_pkg::regnm_t alloc_rd,
    input  logic            alloc_pred_taken,
    input  ooo_pkg::addr_t  alloc_pc,
    output logic            full,
    output ooo_pkg::nick_t  alloc_nick,

    // execution units
    input  logic            ex_en,
    input  ooo_pkg::nick_t  ex_nick,
    input  ooo_pkg::data_t  ex_data,
    input  logic            ex_taken,
    input  ooo_pkg::addr_t  ex_target,

    // store buffer
    output logic            store_commit_en,
    output ooo_pkg::nick_t  store_commit_nick,
    input  logic            store_done_en,
    input  ooo_pkg::nick_t  store_done_nick,

    // retirement
    output logic            commit_en,
    output ooo_pkg::regnm_t commit_rd,
    output ooo_pkg::data_t  commit_data,
    output ooo_pkg::nick_t  commit_nick,
    output logic            flush,
    output ooo_pkg::addr_t  flush_pc,

    // operand read
    input  ooo_pkg::regnm_t rs_regnm,
    output logic            rs_busy,
    output ooo_pkg::nick_t  rs_nick,
    output ooo_pkg::data_t  rs_data
);

    logic alloc_accept;

    rob i_rob (
        .clk               (clk),
        .arst_n            (arst_n),
        .alloc_en          (alloc_en),
        .alloc_op          (alloc_op),
        .alloc_rd          (alloc_rd),
        .alloc_pred_taken  (alloc_pred_taken),
        .alloc_pc          (alloc_pc),
        .full              (full),
        .alloc_nick        (alloc_nick),
        .alloc_accept      (alloc_accept),
        .ex_en             (ex_en),
        .ex_nick           (ex_nick),
        .ex_data           (ex_data),
        .ex_taken          (ex_taken),
        .ex_target         (ex_target),
        .store_done_en     (store_done_en),
        .store_done_nick   (store_done_nick),
        .store_commit_en   (store_commit_en),
        .store_commit_nick (store_commit_nick),
        .commit_en         (commit_en),
        .commit_rd         (commit_rd),
        .commit_data       (commit_data),
        .commit_nick       (commit_nick),
        .flush             (flush),
        .flush_pc          (flush_pc)
    );

    rename_table i_rename_table (
        .clk          (clk),
        .arst_n       (arst_n),
        .alloc_accept (alloc_accept),
        .alloc_rd     (alloc_rd),
        .alloc_nick   (alloc_nick),
        .commit_en    (commit_en),
        .commit_rd    (commit_rd),
        .commit_nick  (commit_nick),
        .flush        (flush),
        .rs_regnm     (rs_regnm),
        .rs_busy      (rs_busy),
        .rs_nick      (rs_nick)
    );

    reg_file i_reg_file (
        .clk         (clk),
        .arst_n      (arst_n),
        .commit_en   (commit_en),
        .commit_rd   (commit_rd),
        .commit_data (commit_data),
        .rs_regnm    (rs_regnm),
        .rs_data     (rs_data)
    );

endmodule

//--- tb/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first 4 rising edges
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

//--- tb/backend_tb.sv
module backend_tb;

    localparam int max_cmds     = 128;
    localparam int reset_cycles = 4;
    localparam int spare_cycles = 50;

    logic            clk;
    logic            arst_n;
    logic            alloc_en;
    ooo_pkg::op_e    alloc_op;
    ooo_pkg::regnm_t alloc_rd;
    logic            alloc_pred_taken;
    ooo_pkg::addr_t  alloc_pc;
    logic            full;
    ooo_pkg::nick_t  alloc_nick;
    logic            ex_en;
    ooo_pkg::nick_t  ex_nick;
    ooo_pkg::data_t  ex_data;
    logic            ex_taken;
    ooo_pkg::addr_t  ex_target;
    logic            store_commit_en;
    ooo_pkg::nick_t  store_commit_nick;
    logic            store_done_en;
    ooo_pkg::nick_t  store_done_nick;
    logic            commit_en;
    ooo_pkg::regnm_t commit_rd;
    ooo_pkg::data_t  commit_data;
    ooo_pkg::nick_t  commit_nick;
    logic            flush;
    ooo_pkg::addr_t  flush_pc;
    ooo_pkg::regnm_t rs_regnm;
    logic            rs_busy;
    ooo_pkg::nick_t  rs_nick;
    ooo_pkg::data_t  rs_data;

    // golden commands, keyword plus up to 7 numeric fields
    string       cmd_kw  [max_cmds];
    logic [31:0] cmd_arg [max_cmds][7];
    int          n_cmds;
    int          cycle_count;
    int          cycle_limit;

    clk_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    ooo_backend_top i_dut (.*);

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input ooo_pkg::data_t exp,
                              input ooo_pkg::data_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_nick(input string name, input ooo_pkg::nick_t exp,
                              input ooo_pkg::nick_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %0d actual %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_regnm(input string name, input ooo_pkg::regnm_t exp,
                               input ooo_pkg::regnm_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected x%0d actual x%0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input ooo_pkg::addr_t exp,
                              input ooo_pkg::addr_t act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error at time %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // called at the sample point, returns at the next drive point
    task automatic finish_cycle(input logic commit_seen, input logic flush_seen);
        if (commit_en && !commit_seen) begin
            $display("commit of tag %0d at time %0t was not expected", commit_nick, $time);
            abort_run();
        end
        if (flush && !flush_seen) begin
            $display("flush at time %0t was not expected", $time);
            abort_run();
        end
        @(posedge clk);
        #1;
        alloc_en      = 1'b0;
        ex_en         = 1'b0;
        store_done_en = 1'b0;
    endtask

    task automatic do_alloc(input int i);
        for (int k = 0; k < cmd_arg[i][0]; k++) begin
            alloc_en         = 1'b1;
            alloc_op         = ooo_pkg::op_e'(cmd_arg[i][1][1:0]);
            alloc_rd         = ooo_pkg::regnm_t'(cmd_arg[i][2]);
            alloc_pred_taken = cmd_arg[i][3][0];
            alloc_pc         = ooo_pkg::addr_t'(cmd_arg[i][4] + 4 * k);
            #2;
            check_bit("full", cmd_arg[i][5][0], full);
            check_nick("alloc_nick", ooo_pkg::nick_t'(cmd_arg[i][6] + k), alloc_nick);
            finish_cycle(1'b0, 1'b0);
        end
    endtask

    task automatic do_ex(input int i);
        ex_en     = 1'b1;
        ex_nick   = ooo_pkg::nick_t'(cmd_arg[i][0]);
        ex_data   = ooo_pkg::data_t'(cmd_arg[i][1]);
        ex_taken  = cmd_arg[i][2][0];
        ex_target = ooo_pkg::addr_t'(cmd_arg[i][3]);
        #2;
        finish_cycle(1'b0, 1'b0);
    endtask

    task automatic do_sdone(input int i);
        store_done_en   = 1'b1;
        store_done_nick = ooo_pkg::nick_t'(cmd_arg[i][0]);
        #2;
        check_bit("commit_en", 1'b0, commit_en);
        finish_cycle(1'b0, 1'b0);
    endtask

    task automatic do_read(input int i);
        rs_regnm = ooo_pkg::regnm_t'(cmd_arg[i][0]);
        #2;
        check_bit("rs_busy", cmd_arg[i][1][0], rs_busy);
        check_nick("rs_nick", ooo_pkg::nick_t'(cmd_arg[i][2]), rs_nick);
        check_data("rs_data", ooo_pkg::data_t'(cmd_arg[i][3]), rs_data);
        finish_cycle(1'b0, 1'b0);
    endtask

    task automatic wait_commit(input int i);
        logic seen;
        seen = 1'b0;
        for (int w = 0; w < cmd_arg[i][3] && !seen; w++) begin
            #2;
            if (commit_en) begin
                seen = 1'b1;
                check_nick("commit_nick", ooo_pkg::nick_t'(cmd_arg[i][2]), commit_nick);
                check_regnm("commit_rd", ooo_pkg::regnm_t'(cmd_arg[i][0]), commit_rd);
                check_data("commit_data", ooo_pkg::data_t'(cmd_arg[i][1]), commit_data);
            end
            finish_cycle(seen, 1'b0);
        end
        if (!seen) begin
            $display("commit of tag %0d did not arrive within %0d cycles",
                     cmd_arg[i][2], cmd_arg[i][3]);
            abort_run();
        end
    endtask

    task automatic wait_store(input int i);
        logic seen;
        seen = 1'b0;
        for (int w = 0; w < cmd_arg[i][1] && !seen; w++) begin
            #2;
            if (store_commit_en) begin
                seen = 1'b1;
                check_nick("store_commit_nick", ooo_pkg::nick_t'(cmd_arg[i][0]),
                           store_commit_nick);
                check_bit("commit_en", 1'b0, commit_en);
            end
            finish_cycle(1'b0, 1'b0);
        end
        if (!seen) begin
            $display("store %0d never reached the head within %0d cycles",
                     cmd_arg[i][0], cmd_arg[i][1]);
            abort_run();
        end
    endtask

    task automatic wait_flush(input int i);
        logic seen;
        seen = 1'b0;
        for (int w = 0; w < cmd_arg[i][1] && !seen; w++) begin
            #2;
            if (flush) begin
                seen = 1'b1;
                check_addr("flush_pc", ooo_pkg::addr_t'(cmd_arg[i][0]), flush_pc);
                check_bit("full", 1'b0, full);
            end
            finish_cycle(1'b0, seen);
        end
        if (!seen) begin
            $display("flush did not arrive within %0d cycles", cmd_arg[i][1]);
            abort_run();
        end
    endtask

    function automatic int cycles_of(input int i);
        case (cmd_kw[i])
            "alloc", "idle": return cmd_arg[i][0];
            "expc":          return cmd_arg[i][3];
            "expst", "expfl": return cmd_arg[i][1];
            default:         return 1;
        endcase
    endfunction

    // numeric fields after each golden keyword
    function automatic int field_count(input string kw);
        case (kw)
            "alloc":            return 7;
            "ex", "expc", "rd": return 4;
            "expst", "expfl":   return 2;
            default:            return 1;
        endcase
    endfunction

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            abort_run();
        end
    end

    initial begin
        int    fd;
        int    rc;
        int    ch;
        string kw;
        alloc_en         = 1'b0;
        alloc_op         = ooo_pkg::op_alu;
        alloc_rd         = '0;
        alloc_pred_taken = 1'b0;
        alloc_pc         = '0;
        ex_en            = 1'b0;
        ex_nick          = '0;
        ex_data          = '0;
        ex_taken         = 1'b0;
        ex_target        = '0;
        store_done_en    = 1'b0;
        store_done_nick  = '0;
        rs_regnm         = '0;
        n_cmds           = 0;
        cycle_count      = 0;
        cycle_limit      = 0;

        fd = $fopen("tb/backend_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file tb/backend_golden.txt could not be opened");
            abort_run();
        end
        while ($fscanf(fd, "%s", kw) == 1) begin
            if (kw.substr(0, 0) == "#") begin
                ch = $fgetc(fd);
                while (ch != "\n" && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (n_cmds == max_cmds) begin
                $display("golden file has more than %0d commands", max_cmds);
                abort_run();
            end else begin
                cmd_kw[n_cmds] = kw;
                case (kw)
                    "alloc": rc = $fscanf(fd, "%d %d %d %d %h %d %d", cmd_arg[n_cmds][0],
                                          cmd_arg[n_cmds][1], cmd_arg[n_cmds][2],
                                          cmd_arg[n_cmds][3], cmd_arg[n_cmds][4],
                                          cmd_arg[n_cmds][5], cmd_arg[n_cmds][6]);
                    "ex":    rc = $fscanf(fd, "%d %h %d %h", cmd_arg[n_cmds][0],
                                          cmd_arg[n_cmds][1], cmd_arg[n_cmds][2],
                                          cmd_arg[n_cmds][3]);
                    "expc":  rc = $fscanf(fd, "%d %h %d %d", cmd_arg[n_cmds][0],
                                          cmd_arg[n_cmds][1], cmd_arg[n_cmds][2],
                                          cmd_arg[n_cmds][3]);
                    "rd":    rc = $fscanf(fd, "%d %d %d %h", cmd_arg[n_cmds][0],
                                          cmd_arg[n_cmds][1], cmd_arg[n_cmds][2],
                                          cmd_arg[n_cmds][3]);
                    "sdone", "idle": rc = $fscanf(fd, "%d", cmd_arg[n_cmds][0]);
                    "expst": rc = $fscanf(fd, "%d %d", cmd_arg[n_cmds][0], cmd_arg[n_cmds][1]);
                    "expfl": rc = $fscanf(fd, "%h %d", cmd_arg[n_cmds][0], cmd_arg[n_cmds][1]);
                    default: begin
                        $display("unknown golden keyword %s", kw);
                        abort_run();
                    end
                endcase
                if (rc != field_count(kw)) begin
                    $display("golden line %s has missing or malformed fields", kw);
                    abort_run();
                end
                n_cmds++;
            end
        end
        $fclose(fd);

        for (int i = 0; i < n_cmds; i++) begin
            cycle_limit += cycles_of(i);
        end
        cycle_limit += reset_cycles + ooo_pkg::reg_count + spare_cycles;

        wait (arst_n === 1'b1);
        @(posedge clk);
        #1;
        // state straight out of reset
        for (int r = 0; r < ooo_pkg::reg_count; r++) begin
            rs_regnm = ooo_pkg::regnm_t'(r);
            #2;
            check_bit("rs_busy", 1'b0, rs_busy);
            check_bit("full", 1'b0, full);
            check_bit("store_commit_en", 1'b0, store_commit_en);
            finish_cycle(1'b0, 1'b0);
        end

        for (int i = 0; i < n_cmds; i++) begin
            case (cmd_kw[i])
                "alloc": do_alloc(i);
                "ex":    do_ex(i);
                "sdone": do_sdone(i);
                "rd":    do_read(i);
                "expc":  wait_commit(i);
                "expst": wait_store(i);
                "expfl": wait_flush(i);
                default: begin
                    repeat (cmd_arg[i][0]) begin
                        #2;
                        finish_cycle(1'b0, 1'b0);
                    end
                end
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

//--- tb/backend_golden.txt
# decimal fields except data, pc and target in hex; op 0 alu 1 load 2 store 3 branch
# alloc count op rd pred pc full nick | ex nick data taken target | sdone nick | idle n
# expc rd data nick window | expst nick window | expfl pc window | rd reg busy nick data
# full and wrap, entry 2 is a mispredicted branch that drains the rob
alloc 1 0 0 0 200 0 1
alloc 1 3 0 0 204 0 2
alloc 29 0 0 0 208 0 3
alloc 1 0 9 0 300 1 1
rd 9 0 0 0
ex 1 a1 0 0
expc 0 a1 1 2
alloc 1 0 0 0 304 0 1
ex 2 b2 1 400
expc 0 b2 2 2
expfl 400 2
# in-order retirement, results arrive 3 1 2
alloc 3 0 1 0 100 0 1
ex 3 33 0 0
ex 1 11 0 0
expc 1 11 1 2
ex 2 22 0 0
expc 1 22 2 2
expc 1 33 3 2
rd 1 0 0 33
# store at the head blocks a done alu entry
alloc 1 2 0 0 500 0 4
alloc 1 0 7 0 504 0 5
ex 5 55 0 0
expst 4 2
idle 2
sdone 4
expc 7 55 5 2
rd 7 0 0 55
# predicted not taken, resolved taken
alloc 1 3 0 0 600 0 6
alloc 2 0 8 0 604 0 7
ex 7 77 0 0
ex 8 88 0 0
ex 6 66 1 700
expc 0 66 6 2
expfl 700 2
rd 8 0 0 0
idle 2
# predicted taken, resolved not taken
alloc 1 3 0 1 800 0 1
ex 1 0 0 900
expc 0 0 1 2
expfl 804 2
# rename of x5, older writer retires first
rd 5 0 0 0
alloc 1 0 5 0 a00 0 1
rd 5 1 1 0
alloc 1 1 5 0 a04 0 2
rd 5 1 2 0
alloc 1 0 0 0 a08 0 3
ex 1 5a5a 0 0
expc 5 5a5a 1 2
rd 5 1 2 5a5a
ex 2 1234 0 0
expc 5 1234 2 2
rd 5 0 0 1234
ex 3 dead 0 0
expc 0 dead 3 2
rd 0 0 0 0
idle 2

//--- sim.f
design/ooo_pkg.sv
design/rob.sv
design/rename_table.sv
design/reg_file.sv
design/ooo_backend_top.sv
tb/clk_gen.sv
tb/backend_tb.sv

//--- Bender.yml
package:
  name: ooo_backend

dependencies: {}

sources:
  - design/ooo_pkg.sv
  - design/rob.sv
  - design/rename_table.sv
  - design/reg_file.sv
  - design/ooo_backend_top.sv
  - target: simulation
    files:
      - tb/clk_gen.sv
      - tb/backend_tb.sv
